// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_eth_tx
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_eth_tx.sv ====
`timescale 1ns/1ps

module tb_eth_tx
    import eth_pkg::*;
();

    localparam int          RAND_FRAMES  = 24;
    localparam int          BURST_FRAMES = 16;              // Short frames, overfill the buffer
    localparam int          NUM_FRAMES   = RAND_FRAMES + BURST_FRAMES;
    localparam int          HDR_LEN      = PREAMBLE_LEN + 1; // Preamble plus SFD
    localparam int          TIMEOUT      = NUM_FRAMES * (300 + IFG_LEN) * 4;
    localparam logic [31:0] SEED         = 32'hb112_7b45;
    localparam crc_t        NORMAL_POLY  = 32'h04C11DB7;    // Non-reflected form of CRC-32

    logic  clk = 1'b0;
    logic  crc_reset;
    logic  wr_en;
    byte_t wr_data;
    logic  wr_last;
    logic  full;
    logic  phy_rdy;
    byte_t tx_data;
    logic  tx_dv;

    logic [31:0] lfsr;
    byte_t       exp_bytes[$];        // Preamble, SFD, payload and pad of queued frames
    int          exp_len[$];          // Payload plus pad per frame
    crc_t        exp_fcs[$];
    int          frames_written = 0;
    int          frames_started = 0;
    int          frames_done    = 0;
    int          cycles         = 0;
    int          stall_left     = 0;
    logic        burst_hold     = 1'b0;   // Keeps phy_rdy low until full is seen
    logic        full_seen      = 1'b0;
    logic        rst_seen       = 1'b1;
    logic        rdy_seen       = 1'b0;   // phy_rdy as the DUT saw it at the last edge
    logic        in_frame       = 1'b0;
    int          pos            = 0;
    int          cur_len        = 0;
    int          gap            = 0;
    crc_t        fcs_acc;

    eth_tx_top u_dut (
        .clk       (clk),
        .crc_reset (crc_reset),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .wr_last   (wr_last),
        .full      (full),
        .phy_rdy   (phy_rdy),
        .tx_data   (tx_data),
        .tx_dv     (tx_dv)
    );

    always #4 clk = ~clk;             // 8 ns period

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s expected 8'h%02h got 8'h%02h",
                               $time, name, exp, got));
        end
    endtask

    task automatic check_fcs(input string name, input crc_t got, input crc_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s expected 32'h%08h got 32'h%08h",
                               $time, name, exp, got));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};    // One step per bit taken
        end
        return r;
    endfunction

    // MSB-first CRC-32 over bits in wire order
    function automatic crc_t crc_fold(input crc_t crc, input byte_t b);
        crc_t c;
        logic fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[31] ^ b[k];        // Octets go out bit 0 first
            c  = {c[30:0], 1'b0};
            if (fb)
                c = c ^ NORMAL_POLY;
        end
        return c;
    endfunction

    // Bit reversal gives the register in wire order, sent low byte first
    function automatic crc_t fcs_of(input crc_t crc);
        crc_t r;
        for (int k = 0; k < 32; k++)
            r[k] = ~crc[31-k];
        return r;
    endfunction

    // One clock, then drive phy_rdy 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
        if (full)
            full_seen = 1'b1;
        if (burst_hold) begin
            phy_rdy = 1'b0;
            if (full)
                burst_hold = 1'b0;    // Buffer proven full, let the MAC drain
        end else if (stall_left != 0) begin
            phy_rdy    = 1'b0;
            stall_left = stall_left - 1;
        end else if (rand_bits(3) == 0) begin
            phy_rdy    = 1'b0;        // About one cycle in eight starts a stall
            stall_left = int'(rand_bits(2));
        end else begin
            phy_rdy = 1'b1;
        end
    endtask

    task automatic write_frame(input int len, input logic gaps);
        byte_t pay[$];
        crc_t  crc;
        int    padded;
        crc    = CRC_INIT;
        padded = (len < MIN_FRAME_LEN) ? MIN_FRAME_LEN : len;
        for (int i = 0; i < len; i++)
            pay.push_back(byte_t'(rand_bits(8)));
        // Expected wire image
        for (int i = 0; i < PREAMBLE_LEN; i++)
            exp_bytes.push_back(ETH_PREAMBLE_BYTE);
        exp_bytes.push_back(ETH_SFD_BYTE);
        for (int i = 0; i < padded; i++) begin
            exp_bytes.push_back((i < len) ? pay[i] : ETH_PAD_BYTE);
            crc = crc_fold(crc, (i < len) ? pay[i] : ETH_PAD_BYTE);
        end
        exp_len.push_back(padded);
        exp_fcs.push_back(fcs_of(crc));
        for (int i = 0; i < len; i++) begin
            while (gaps && rand_bits(2) == 0) begin
                wr_en = 1'b0;         // Idle cycle on the write side
                next_cycle();
            end
            while (full) begin
                wr_en = 1'b0;
                next_cycle();
            end
            wr_en   = 1'b1;
            wr_data = pay[i];
            wr_last = (i == len - 1);
            next_cycle();             // Accepted at this edge
        end
        wr_en          = 1'b0;
        wr_last        = 1'b0;
        frames_written = frames_written + 1;
    endtask

    // One enabled output cycle
    task automatic monitor_step();
        if (tx_dv) begin
            if (!in_frame) begin
                if (frames_started >= frames_written)
                    fail_run("tx_dv rose before a complete frame had been written");
                if (frames_started > 0 && gap < IFG_LEN)
                    fail_run($sformatf("inter-frame gap of %0d cycles is below %0d",
                                       gap, IFG_LEN));
                in_frame       = 1'b1;
                pos            = 0;
                cur_len        = exp_len.pop_front();
                frames_started = frames_started + 1;
            end
            if (pos < HDR_LEN + cur_len)
                check_byte("tx_data", tx_data, exp_bytes.pop_front());
            else
                fcs_acc[(pos - HDR_LEN - cur_len)*8 +: 8] = tx_data;   // Low byte first
            pos = pos + 1;
            if (pos == HDR_LEN + cur_len + FCS_LEN) begin
                check_fcs("tx_data fcs", fcs_acc, exp_fcs.pop_front());
                in_frame    = 1'b0;
                gap         = 0;
                frames_done = frames_done + 1;
            end
        end else begin
            if (in_frame)
                fail_run("tx_dv dropped in the middle of a frame");
            gap = gap + 1;
        end
    endtask

    always @(posedge clk) begin
        rst_seen = crc_reset;
        rdy_seen = phy_rdy;
        cycles   = cycles + 1;
        if (cycles > TIMEOUT)
            fail_run($sformatf("timeout after %0d cycles, %0d of %0d frames seen",
                               cycles, frames_done, NUM_FRAMES));
    end

    // Outputs are settled by the falling edge, frozen cycles skipped
    always @(negedge clk) begin
        if (!rst_seen && rdy_seen)
            monitor_step();
    end

    initial begin
        crc_t  c;
        string s;
        crc_reset = 1'b1;
        wr_en     = 1'b0;
        wr_data   = '0;
        wr_last   = 1'b0;
        phy_rdy   = 1'b1;
        lfsr      = SEED;
        s         = "123456789";
        c         = CRC_INIT;
        for (int i = 0; i < s.len(); i++)
            c = crc_fold(c, byte_t'(s[i]));
        check_fcs("model check value", fcs_of(c), 32'hCBF43926);   // Standard CRC-32 check
        repeat (3) @(posedge clk);
        #1 crc_reset = 1'b0;
        repeat (20) next_cycle();     // Nothing written yet, tx_dv must stay low
        for (int f = 0; f < RAND_FRAMES; f++) begin
            write_frame(1 + int'(rand_bits(8) % 200), 1'b1);
            repeat (int'(rand_bits(4))) next_cycle();
        end
        burst_hold = 1'b1;
        for (int f = 0; f < BURST_FRAMES; f++)
            write_frame(17 + int'(rand_bits(4)), 1'b0);   // At least 272 bytes in total
        burst_hold = 1'b0;
        while (frames_done < NUM_FRAMES)
            next_cycle();
        repeat (2 * IFG_LEN + 20) next_cycle();             // No stray frame afterwards
        if (!full_seen)
            fail_run("full never rose during the short frame burst");
        else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== hdl/crc32.sv ====
`timescale 1ns/1ps

module crc32
    import eth_pkg::*;
(
    input  logic  clk,
    input  logic  crc_reset,
    input  logic  crc_clear,      // Restart for a new frame
    input  logic  crc_en,         // Fold crc_byte this cycle
    input  byte_t crc_byte,
    output crc_t  crc_value       // Raw register, not yet complemented
);

    crc_t crc_reg;

    // One byte through the LFSR, bit 0 first as on the wire
    function automatic crc_t crc_step(crc_t crc_in, byte_t data);
        crc_t c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i])
                c = (c >> 1) ^ CRC_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (crc_reset || crc_clear) begin
            crc_reg <= CRC_INIT;                 // Clear wins over a fold
        end else if (crc_en) begin
            crc_reg <= crc_step(crc_reg, crc_byte);
        end
    end

    assign crc_value = crc_reg;

endmodule

// ==== hdl/eth_pkg.sv ====
package eth_pkg;

    // Octet values on the wire
    localparam logic [7:0] ETH_PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] ETH_SFD_BYTE      = 8'hD5;
    localparam logic [7:0] ETH_PAD_BYTE      = 8'h00;

    // Frame geometry in bytes
    localparam int PREAMBLE_LEN  = 7;            // Preamble only, SFD is separate
    localparam int MIN_FRAME_LEN = 60;           // Payload plus pad, FCS excluded
    localparam int FCS_LEN       = 4;
    localparam int IFG_LEN       = 12;           // 96 bit times at one byte per clock

    // Store-and-forward buffer
    localparam int FIFO_DEPTH = 256;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // Counter widths inside the MAC
    localparam int BYTE_CNT_W  = $clog2(IFG_LEN);         // Largest of preamble, FCS, IFG
    localparam int FRAME_LEN_W = $clog2(MIN_FRAME_LEN + 1);  // Saturates at MIN_FRAME_LEN

    // Reflected CRC-32 as used by 802.3
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    typedef logic [7:0]         byte_t;
    typedef logic [31:0]        crc_t;
    typedef logic [FIFO_AW-1:0] fifo_addr_t;
    typedef logic [7:0]         frame_cnt_t;

    // Transmit framing states, in wire order
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        PAYLOAD,
        PAD,
        FCS,
        IFG
    } mac_state_t;

endpackage

// ==== hdl/eth_tx_top.sv ====
`timescale 1ns/1ps

module eth_tx_top
    import eth_pkg::*;
(
    input  logic  clk,
    input  logic  crc_reset,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  wr_last,
    output logic  full,
    input  logic  phy_rdy,
    output byte_t tx_data,
    output logic  tx_dv
);

    // Buffer to MAC
    logic  rd_en;
    byte_t rd_data;
    logic  rd_last;
    logic  frame_avail;

    // MAC to CRC and back
    logic  crc_clear;
    logic  crc_en;
    byte_t crc_byte;
    crc_t  crc_value;

    tx_frame_fifo u_fifo (
        .clk         (clk),
        .crc_reset   (crc_reset),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_last     (wr_last),
        .full        (full),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .rd_last     (rd_last),
        .frame_avail (frame_avail)
    );

    tx_mac u_mac (
        .clk         (clk),
        .crc_reset   (crc_reset),
        .frame_avail (frame_avail),
        .rd_data     (rd_data),
        .rd_last     (rd_last),
        .rd_en       (rd_en),
        .phy_rdy     (phy_rdy),
        .crc_clear   (crc_clear),
        .crc_en      (crc_en),
        .crc_byte    (crc_byte),
        .crc_value   (crc_value),
        .tx_data     (tx_data),
        .tx_dv       (tx_dv)
    );

    crc32 u_crc (
        .clk       (clk),
        .crc_reset (crc_reset),
        .crc_clear (crc_clear),
        .crc_en    (crc_en),
        .crc_byte  (crc_byte),
        .crc_value (crc_value)
    );

endmodule

// ==== hdl/tx_frame_fifo.sv ====
`timescale 1ns/1ps

module tx_frame_fifo
    import eth_pkg::*;
(
    input  logic  clk,
    input  logic  crc_reset,
    input  logic  wr_en,
    input  byte_t wr_data,
    input  logic  wr_last,        // Marks the final payload byte of a frame
    output logic  full,
    input  logic  rd_en,          // Pop the head this cycle
    output byte_t rd_data,
    output logic  rd_last,
    output logic  frame_avail     // At least one whole frame is stored
);

    logic [8:0]       mem [FIFO_DEPTH];  // {last, data}
    fifo_addr_t       wr_ptr;
    fifo_addr_t       rd_ptr;
    logic [FIFO_AW:0] count;             // Occupancy, needs one extra bit for full
    frame_cnt_t       frame_cnt;
    logic             frame_in;
    logic             frame_out;

    assign frame_in  = wr_en && wr_last;
    assign frame_out = rd_en && rd_last;

    // Byte and last flag storage
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= {wr_last, wr_data};
    end

    always_ff @(posedge clk) begin
        if (crc_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            frame_cnt <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at FIFO_DEPTH
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
            // Completed frames in minus frames fully drained
            case ({frame_in, frame_out})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

    // Head of buffer, read combinationally
    assign rd_data     = mem[rd_ptr][7:0];
    assign rd_last     = mem[rd_ptr][8];
    assign full        = (count == FIFO_DEPTH);
    assign frame_avail = (frame_cnt != '0);

    // Writer side must honour full
    a_no_write_when_full: assert property (@(posedge clk) disable iff (crc_reset)
        wr_en |-> !full);

    // MAC only pops inside a stored frame
    a_no_read_when_empty: assert property (@(posedge clk) disable iff (crc_reset)
        rd_en |-> (count != '0));

endmodule

// ==== hdl/tx_mac.sv ====
`timescale 1ns/1ps

module tx_mac
    import eth_pkg::*;
(
    input  logic  clk,
    input  logic  crc_reset,
    input  logic  frame_avail,    // Buffer holds a complete frame
    input  byte_t rd_data,
    input  logic  rd_last,
    output logic  rd_en,
    input  logic  phy_rdy,        // Low freezes the whole transmitter
    output logic  crc_clear,
    output logic  crc_en,
    output byte_t crc_byte,
    input  crc_t  crc_value,
    output byte_t tx_data,
    output logic  tx_dv
);

    mac_state_t             state, state_next;
    logic [BYTE_CNT_W-1:0]  byte_cnt, byte_cnt_next;     // Preamble, FCS and IFG position
    logic [FRAME_LEN_W-1:0] frame_len, frame_len_next;   // Payload plus pad so far
    logic [FRAME_LEN_W-1:0] len_inc;
    byte_t                  tx_data_reg, tx_data_next;
    logic                   tx_dv_reg, tx_dv_next;
    crc_t                   fcs;

    assign len_inc = frame_len + 1'b1;
    assign fcs     = ~crc_value;           // FCS is the complemented register

    // Next state and output byte
    always_comb begin
        state_next     = state;
        byte_cnt_next  = byte_cnt;
        frame_len_next = frame_len;
        tx_data_next   = tx_data_reg;
        tx_dv_next     = 1'b0;             // Only framing states drive valid

        case (state)
            IDLE: begin
                if (frame_avail) begin
                    tx_data_next  = ETH_PREAMBLE_BYTE;   // First preamble byte
                    tx_dv_next    = 1'b1;
                    byte_cnt_next = BYTE_CNT_W'(1);
                    state_next    = PREAMBLE;
                end
            end
            PREAMBLE: begin
                tx_data_next  = ETH_PREAMBLE_BYTE;
                tx_dv_next    = 1'b1;
                byte_cnt_next = byte_cnt + 1'b1;
                if (byte_cnt == BYTE_CNT_W'(PREAMBLE_LEN - 1))
                    state_next = SFD;    // Seventh byte leaves now
            end
            SFD: begin
                tx_data_next   = ETH_SFD_BYTE;
                tx_dv_next     = 1'b1;
                frame_len_next = '0;
                state_next     = PAYLOAD;
            end
            PAYLOAD: begin
                tx_data_next = rd_data;            // Popped byte goes out next cycle
                tx_dv_next   = 1'b1;
                if (frame_len != FRAME_LEN_W'(MIN_FRAME_LEN))
                    frame_len_next = len_inc;      // Saturate once minimum reached
                if (rd_last) begin
                    byte_cnt_next = '0;
                    if (len_inc < FRAME_LEN_W'(MIN_FRAME_LEN))
                        state_next = PAD;
                    else
                        state_next = FCS;
                end
            end
            PAD: begin
                tx_data_next   = ETH_PAD_BYTE;
                tx_dv_next     = 1'b1;
                frame_len_next = len_inc;
                if (len_inc == FRAME_LEN_W'(MIN_FRAME_LEN))
                    state_next = FCS;              // 60th byte leaves now
            end
            FCS: begin
                tx_data_next  = fcs[byte_cnt[1:0]*8 +: 8];   // Low byte first
                tx_dv_next    = 1'b1;
                byte_cnt_next = byte_cnt + 1'b1;
                if (byte_cnt == BYTE_CNT_W'(FCS_LEN - 1)) begin
                    byte_cnt_next = '0;
                    state_next    = IFG;
                end
            end
            IFG: begin
                byte_cnt_next = byte_cnt + 1'b1;
                if (byte_cnt == BYTE_CNT_W'(IFG_LEN - 1))
                    state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // Control registers hold while the PHY stalls
    always_ff @(posedge clk) begin
        if (crc_reset) begin
            state     <= IDLE;
            byte_cnt  <= '0;
            frame_len <= '0;
            tx_dv_reg <= 1'b0;
        end else if (phy_rdy) begin
            state     <= state_next;
            byte_cnt  <= byte_cnt_next;
            frame_len <= frame_len_next;
            tx_dv_reg <= tx_dv_next;
        end
    end

    always_ff @(posedge clk) begin
        if (phy_rdy)
            tx_data_reg <= tx_data_next;   // Data register, qualified by tx_dv
    end

    // Strobes are dropped during a stall
    assign rd_en     = phy_rdy && (state == PAYLOAD);
    assign crc_en    = phy_rdy && (state == PAYLOAD || state == PAD);
    assign crc_clear = phy_rdy && (state == IDLE) && frame_avail;
    assign crc_byte  = (state == PAYLOAD) ? rd_data : ETH_PAD_BYTE;

    assign tx_data = tx_data_reg;
    assign tx_dv   = tx_dv_reg;

    // Last FCS byte is still on the wire during the first IFG cycle
    a_dv_low_in_gap: assert property (@(posedge clk) disable iff (crc_reset)
        (state == IDLE || (state == IFG && byte_cnt != '0)) |-> !tx_dv);

    // Pops never run ahead of a complete frame in the buffer
    a_rd_inside_frame: assert property (@(posedge clk) disable iff (crc_reset)
        rd_en |-> frame_avail);

endmodule

// ==== tb.f ====
hdl/eth_pkg.sv
hdl/crc32.sv
hdl/tx_frame_fifo.sv
hdl/tx_mac.sv
hdl/eth_tx_top.sv
bench/tb_eth_tx.sv
